// ==== logic/alu_datapath.sv ====
// ==============================
// A, X, Y, flags and ALU
// ==============================
`timescale 1ns/1ps

module alu_datapath
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic  raw_clk,
  input  logic  button_reset,
  exec_if.dp    ex,
  output byte_t acc
);

  byte_t      a_q;
  byte_t      x_q;
  byte_t      y_q;
  logic       n_q;
  logic       z_q;
  logic       c_q;
  byte_t      addend;
  byte_t      result;
  logic [8:0] sum;
  logic       carry_in;
  logic       c_next;
  logic       write_a;
  logic       write_x;
  logic       write_y;
  logic       write_c;
  logic       compare;
  logic       update_nz;

  // SBC and CMP add the inverted operand and CMP forces the carry in
  assign addend   = (ex.op == OP_SBC || ex.op == OP_CMP) ? ~ex.operand : ex.operand;
  assign carry_in = (ex.op == OP_CMP) ? 1'b1 : c_q;
  assign sum      = {1'b0, a_q} + {1'b0, addend} + {8'h00, carry_in};

  always_comb
  begin
    result  = sum[7:0];
    c_next  = sum[8];
    write_a = 1'b0;
    write_x = 1'b0;
    write_y = 1'b0;
    write_c = 1'b0;
    compare = 1'b0;
    case (ex.op)
      OP_ORA:
        begin
          result  = a_q | ex.operand;
          write_a = 1'b1;
        end
      OP_AND:
        begin
          result  = a_q & ex.operand;
          write_a = 1'b1;
        end
      OP_EOR:
        begin
          result  = a_q ^ ex.operand;
          write_a = 1'b1;
        end
      OP_ADC, OP_SBC:
        begin
          write_a = 1'b1;
          write_c = 1'b1;
        end
      OP_CMP:
        begin
          compare = 1'b1;
          write_c = 1'b1;
        end
      OP_LDA:
        begin
          result  = ex.operand;
          write_a = 1'b1;
        end
      OP_LDX:
        begin
          result  = ex.operand;
          write_x = 1'b1;
        end
      OP_TAX:
        begin
          result  = a_q;
          write_x = 1'b1;
        end
      OP_TXA:
        begin
          result  = x_q;
          write_a = 1'b1;
        end
      OP_TAY:
        begin
          result  = a_q;
          write_y = 1'b1;
        end
      OP_TYA:
        begin
          result  = y_q;
          write_a = 1'b1;
        end
      OP_INX:
        begin
          result  = x_q + 8'd1;
          write_x = 1'b1;
        end
      OP_INY:
        begin
          result  = y_q + 8'd1;
          write_y = 1'b1;
        end
      OP_DEX:
        begin
          result  = x_q - 8'd1;
          write_x = 1'b1;
        end
      OP_DEY:
        begin
          result  = y_q - 8'd1;
          write_y = 1'b1;
        end
      OP_CLC:
        begin
          c_next  = 1'b0;
          write_c = 1'b1;
        end
      OP_SEC:
        begin
          c_next  = 1'b1;
          write_c = 1'b1;
        end
      // Stores, jumps, BRK and NOP leave the registers alone
      default: ;
    endcase
  end

  assign update_nz = write_a | write_x | write_y | compare;

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      a_q <= '0;
      x_q <= '0;
      y_q <= '0;
      n_q <= 1'b0;
      z_q <= 1'b0;
      c_q <= 1'b0;
    end
    else if (ex.execute)
    begin
      if (write_a) a_q <= result;
      if (write_x) x_q <= result;
      if (write_y) y_q <= result;
      if (update_nz)
      begin
        n_q <= result[7];
        z_q <= (result == 8'h00);
      end
      if (write_c) c_q <= c_next;
    end
  end

  always_comb
  begin
    ex.status         = STATUS_BASE;
    ex.status[FLAG_N] = n_q;
    ex.status[FLAG_Z] = z_q;
    ex.status[FLAG_C] = c_q;
  end

  assign ex.store_data = (ex.op == OP_STX) ? x_q : a_q;
  assign ex.index_x    = x_q;
  assign ex.index_y    = y_q;
  assign acc           = a_q;

  a_single_execute: assert property (@(posedge raw_clk) disable iff (!button_reset)
    ex.execute |=> !ex.execute);

  a_known_op: assert property (@(posedge raw_clk) disable iff (!button_reset)
    ex.execute |-> !$isunknown(ex.op));

endmodule

// ==== logic/bus_sequencer.sv ====
// ==============================
// Bus sequencer FSM, PC and effective address
// ==============================
`timescale 1ns/1ps

module bus_sequencer
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  logic  raw_clk,
  input  logic  button_reset,
  input  logic  button_halt,
  input  byte_t mem_rdata,
  output addr_t mem_address,
  output byte_t mem_wdata,
  output logic  mem_write,
  output addr_t pc,
  output logic  halted,
  output logic  fault,
  exec_if.seq   ex
);

  seq_state_e state;
  byte_t      opcode_q;
  byte_t      operand_q;
  byte_t      decode_byte;
  byte_t      zp_addr;
  addr_t      ea_q;
  addr_t      abs_addr;
  op_class_e  op;
  addr_mode_e mode;
  logic       illegal;
  logic       is_store;

  // Decode straight off the bus while the opcode is being latched
  assign decode_byte = (state == LATCH_OP) ? mem_rdata : opcode_q;

  opcode_decoder u_decoder (
    .opcode  (decode_byte),
    .op      (op),
    .mode    (mode),
    .illegal (illegal)
  );

  assign is_store = (op == OP_STA) || (op == OP_STX);

  // Zero page X wraps inside page zero
  assign zp_addr  = (mode == MODE_ZP_X) ? mem_rdata + ex.index_x : mem_rdata;
  assign abs_addr = {mem_rdata, operand_q} +
                    ((mode == MODE_ABS_X) ? {8'h00, ex.index_x} :
                     (mode == MODE_ABS_Y) ? {8'h00, ex.index_y} : 16'h0000);

  assign mem_address = (state == FETCH_DATA || state == LATCH_DATA || state == STORE) ?
                       ea_q : pc;
  assign mem_wdata   = ex.store_data;
  assign halted      = (state == HALTED);
  assign fault       = (state == ERROR);

  assign ex.op      = op;
  assign ex.operand = operand_q;
  assign ex.execute = (state == EXECUTE);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state     <= FETCH_OP;
      pc        <= RESET_VECTOR;
      opcode_q  <= OPC_NOP;
      mem_write <= 1'b0;
    end
    else
    begin
      mem_write <= 1'b0;
      case (state)
        FETCH_OP: state <= button_halt ? LATCH_OP : HALTED;
        LATCH_OP:
          begin
            opcode_q <= mem_rdata;
            pc       <= pc + 16'd1;
            if (illegal)
              state <= ERROR;
            else if (mode == MODE_IMPLIED)
              state <= EXECUTE;
            else
              state <= FETCH_LO;
          end
        FETCH_LO: state <= LATCH_LO;
        LATCH_LO:
          begin
            // Low address byte or immediate value
            operand_q <= mem_rdata;
            pc        <= pc + 16'd1;
            ea_q      <= {8'h00, zp_addr};
            case (mode)
              MODE_IMMEDIATE:    state <= EXECUTE;
              MODE_ZP, MODE_ZP_X: state <= FETCH_DATA;
              default:           state <= FETCH_HI;
            endcase
          end
        FETCH_HI: state <= LATCH_HI;
        LATCH_HI:
          begin
            if (op == OP_JMP)
            begin
              pc    <= {mem_rdata, operand_q};
              state <= FETCH_OP;
            end
            else
            begin
              pc    <= pc + 16'd1;
              ea_q  <= abs_addr;
              state <= FETCH_DATA;
            end
          end
        // Stores present ea once without using the read data
        FETCH_DATA: state <= is_store ? EXECUTE : LATCH_DATA;
        LATCH_DATA:
          begin
            operand_q <= mem_rdata;
            state     <= EXECUTE;
          end
        EXECUTE:
          begin
            if (op == OP_BRK)
              state <= HALTED;
            else if (is_store)
            begin
              state     <= STORE;
              mem_write <= 1'b1;
            end
            else
              state <= FETCH_OP;
          end
        STORE:  state <= FETCH_OP;
        HALTED: state <= button_halt ? HALTED : FETCH_OP;
        default: state <= ERROR;
      endcase
    end
  end

  a_write_in_store: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_write |-> state == STORE);

  a_pc_held: assert property (@(posedge raw_clk) disable iff (!button_reset)
    state == HALTED |=> $stable(pc));

endmodule

// ==== logic/cpu_bus_pkg.sv ====
// ==============================
// Bus widths, reset vector, flags, sequencer states
// ==============================

package cpu_bus_pkg;

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [7:0]  status_t;

  // First opcode fetch after reset
  localparam addr_t RESET_VECTOR = 16'h4000;

  localparam int FLAG_N = 7;
  localparam int FLAG_Z = 1;
  localparam int FLAG_C = 0;

  // Unused bit 5 reads as one
  localparam status_t STATUS_BASE = 8'h20;

  typedef enum logic [3:0] {
    FETCH_OP, LATCH_OP, FETCH_LO, LATCH_LO, FETCH_HI, LATCH_HI,
    FETCH_DATA, LATCH_DATA, EXECUTE, STORE, HALTED, ERROR
  } seq_state_e;

endpackage

// ==== logic/cpu_core.sv ====
// ==============================
// CPU top level
// ==============================
`timescale 1ns/1ps

module cpu_core
  import cpu_bus_pkg::*;
(
  input  logic    raw_clk,
  input  logic    button_reset,
  input  logic    button_halt,
  input  byte_t   mem_rdata,
  output addr_t   mem_address,
  output byte_t   mem_wdata,
  output logic    mem_write,
  output byte_t   acc,
  output status_t status,
  output addr_t   pc,
  output logic    halted,
  output logic    fault
);

  exec_if ex_bus ();

  bus_sequencer u_sequencer (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_rdata    (mem_rdata),
    .mem_address  (mem_address),
    .mem_wdata    (mem_wdata),
    .mem_write    (mem_write),
    .pc           (pc),
    .halted       (halted),
    .fault        (fault),
    .ex           (ex_bus.seq)
  );

  alu_datapath u_datapath (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .ex           (ex_bus.dp),
    .acc          (acc)
  );

  assign status = ex_bus.status;

endmodule

// ==== logic/cpu_isa_pkg.sv ====
// ==============================
// Opcode fields, opcode and mode codes, op classes
// ==============================

package cpu_isa_pkg;

  typedef logic [2:0] op_field_t;
  typedef logic [2:0] mode_field_t;

  // cc field of aaabbbcc
  localparam logic [1:0] GROUP_CTRL = 2'b00;
  localparam logic [1:0] GROUP_ALU  = 2'b01;
  localparam logic [1:0] GROUP_RMW  = 2'b10;

  // bbb codes of group one unless marked RMW
  localparam mode_field_t BBB_RMW_IMM = 3'b000;
  localparam mode_field_t BBB_ZP      = 3'b001;
  localparam mode_field_t BBB_IMM     = 3'b010;
  localparam mode_field_t BBB_ABS     = 3'b011;
  localparam mode_field_t BBB_ZP_X    = 3'b101;
  localparam mode_field_t BBB_ABS_Y   = 3'b110;
  localparam mode_field_t BBB_ABS_X   = 3'b111;

  // aaa codes shared by STA/STX and LDA/LDX
  localparam op_field_t AAA_STORE  = 3'b100;
  localparam op_field_t AAA_LOAD_X = 3'b101;

  // Single-byte opcodes
  localparam logic [7:0] OPC_BRK = 8'h00;
  localparam logic [7:0] OPC_CLC = 8'h18;
  localparam logic [7:0] OPC_SEC = 8'h38;
  localparam logic [7:0] OPC_JMP = 8'h4c;
  localparam logic [7:0] OPC_DEY = 8'h88;
  localparam logic [7:0] OPC_TXA = 8'h8a;
  localparam logic [7:0] OPC_TYA = 8'h98;
  localparam logic [7:0] OPC_TAY = 8'ha8;
  localparam logic [7:0] OPC_TAX = 8'haa;
  localparam logic [7:0] OPC_INY = 8'hc8;
  localparam logic [7:0] OPC_DEX = 8'hca;
  localparam logic [7:0] OPC_INX = 8'he8;
  localparam logic [7:0] OPC_NOP = 8'hea;

  typedef enum logic [2:0] {
    MODE_IMPLIED, MODE_IMMEDIATE, MODE_ZP, MODE_ZP_X, MODE_ABS, MODE_ABS_X, MODE_ABS_Y
  } addr_mode_e;

  // First eight entries follow the group one aaa order
  typedef enum logic [4:0] {
    OP_ORA, OP_AND, OP_EOR, OP_ADC, OP_STA, OP_LDA, OP_CMP, OP_SBC,
    OP_LDX, OP_STX, OP_CLC, OP_SEC, OP_TAX, OP_TXA, OP_TAY, OP_TYA,
    OP_INX, OP_INY, OP_DEX, OP_DEY, OP_NOP, OP_JMP, OP_BRK
  } op_class_e;

endpackage

// ==== logic/exec_if.sv ====
// ==============================
// Execute control and results
// ==============================
`timescale 1ns/1ps

interface exec_if
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
();

  // Sequencer side
  op_class_e op;
  byte_t     operand;
  logic      execute;

  // Datapath side
  byte_t     store_data;
  byte_t     index_x;
  byte_t     index_y;
  status_t   status;

  modport seq (output op, operand, execute, input store_data, index_x, index_y);

  modport dp (input op, operand, execute, output store_data, index_x, index_y, status);

endinterface

// ==== logic/opcode_decoder.sv ====
// ==============================
// Opcode to op class and mode
// ==============================
`timescale 1ns/1ps

module opcode_decoder
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
(
  input  byte_t      opcode,
  output op_class_e  op,
  output addr_mode_e mode,
  output logic       illegal
);

  op_field_t   aaa;
  mode_field_t bbb;
  logic [1:0]  cc;

  assign aaa = opcode[7:5];
  assign bbb = opcode[4:2];
  assign cc  = opcode[1:0];

  always_comb
  begin
    op      = OP_NOP;
    mode    = MODE_IMPLIED;
    illegal = 1'b0;
    case (cc)
      GROUP_ALU:
        begin
          op = op_class_e'({2'b00, aaa});
          case (bbb)
            BBB_ZP:    mode = MODE_ZP;
            BBB_IMM:   mode = MODE_IMMEDIATE;
            BBB_ABS:   mode = MODE_ABS;
            BBB_ZP_X:  mode = MODE_ZP_X;
            BBB_ABS_Y: mode = MODE_ABS_Y;
            BBB_ABS_X: mode = MODE_ABS_X;
            // Indirect modes are not supported
            default:   illegal = 1'b1;
          endcase
          // No immediate store
          if (aaa == AAA_STORE && bbb == BBB_IMM)
            illegal = 1'b1;
        end
      GROUP_RMW:
        begin
          case (opcode)
            OPC_TXA: op = OP_TXA;
            OPC_TAX: op = OP_TAX;
            OPC_DEX: op = OP_DEX;
            OPC_NOP: op = OP_NOP;
            default:
              begin
                op = (aaa == AAA_STORE) ? OP_STX : OP_LDX;
                case (bbb)
                  BBB_RMW_IMM: mode = MODE_IMMEDIATE;
                  BBB_ZP:      mode = MODE_ZP;
                  BBB_ABS:     mode = MODE_ABS;
                  default:     illegal = 1'b1;
                endcase
                if (aaa != AAA_STORE && aaa != AAA_LOAD_X)
                  illegal = 1'b1;
                if (aaa == AAA_STORE && bbb == BBB_RMW_IMM)
                  illegal = 1'b1;
              end
          endcase
        end
      GROUP_CTRL:
        begin
          case (opcode)
            OPC_BRK: op = OP_BRK;
            OPC_JMP:
              begin
                op   = OP_JMP;
                mode = MODE_ABS;
              end
            OPC_CLC: op = OP_CLC;
            OPC_SEC: op = OP_SEC;
            OPC_TYA: op = OP_TYA;
            OPC_DEY: op = OP_DEY;
            OPC_TAY: op = OP_TAY;
            OPC_INY: op = OP_INY;
            OPC_INX: op = OP_INX;
            default: illegal = 1'b1;
          endcase
        end
      default: illegal = 1'b1;
    endcase
  end

endmodule

// ==== include/ref_model.svh ====
// ==============================
// Instruction-level reference model and its memory image
// ==============================
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

byte_t ref_mem [0:65535];
byte_t ref_a;
byte_t ref_x;
byte_t ref_y;
logic  ref_n;
logic  ref_z;
logic  ref_c;
addr_t ref_pc;
addr_t ref_wr_addr [$];
byte_t ref_wr_data [$];

// Returns 0 for implied, 1 imm, 2 zp, 3 zp,x, 4 abs, 5 abs,x, 6 abs,y and -1 if illegal
function automatic int ref_mode(input byte_t opc);
  if (opc[1:0] == 2'b01 && opc != 8'h89)
    case (opc[4:2])
      3'd1: return 2;
      3'd2: return 1;
      3'd3: return 4;
      3'd5: return 3;
      3'd6: return 6;
      3'd7: return 5;
      default: return -1;
    endcase
  case (opc)
    8'ha2: return 1;
    8'ha6, 8'h86: return 2;
    8'hae, 8'h8e, OPC_JMP: return 4;
    OPC_BRK, OPC_CLC, OPC_SEC, OPC_TAX, OPC_TXA, OPC_TAY, OPC_TYA,
    OPC_INX, OPC_INY, OPC_DEX, OPC_DEY, OPC_NOP: return 0;
    default: return -1;
  endcase
endfunction

function automatic void ref_reset();
  ref_a  = 8'h00;
  ref_x  = 8'h00;
  ref_y  = 8'h00;
  ref_n  = 1'b0;
  ref_z  = 1'b0;
  ref_c  = 1'b0;
  ref_pc = 16'h4000;
  ref_wr_addr.delete();
  ref_wr_data.delete();
endfunction

function automatic void ref_set_nz(input byte_t r);
  ref_n = r[7];
  ref_z = (r == 8'h00);
endfunction

function automatic status_t ref_status();
  return {ref_n, 1'b0, 1'b1, 3'b000, ref_z, ref_c};
endfunction

function automatic void ref_store(input addr_t ea, input byte_t d);
  ref_mem[ea] = d;
  ref_wr_addr.push_back(ea);
  ref_wr_data.push_back(d);
endfunction

// Runs from ref_pc to BRK or an illegal opcode and returns 1 on an illegal one
function automatic logic run_reference(input int max_steps);
  byte_t      opc;
  byte_t      lo;
  byte_t      hi;
  byte_t      m;
  addr_t      ea;
  logic [8:0] sum;
  int         mode;
  for (int step = 0; step < max_steps; step++)
  begin
    opc    = ref_mem[ref_pc];
    mode   = ref_mode(opc);
    ref_pc = ref_pc + 16'd1;
    if (mode < 0)
      return 1'b1;
    if (opc == OPC_BRK)
      return 1'b0;
    lo = ref_mem[ref_pc];
    hi = ref_mem[ref_pc + 16'd1];
    if (mode != 0)
      ref_pc = ref_pc + ((mode >= 4) ? 16'd2 : 16'd1);
    case (mode)
      2: ea = {8'h00, lo};
      3: ea = {8'h00, byte_t'(lo + ref_x)};
      4: ea = {hi, lo};
      5: ea = {hi, lo} + {8'h00, ref_x};
      6: ea = {hi, lo} + {8'h00, ref_y};
      default: ea = 16'h0000;
    endcase
    m = (mode == 1) ? lo : ref_mem[ea];
    if (opc[1:0] == 2'b01)
    begin
      case (opc[7:5])
        3'd0: ref_a = ref_a | m;
        3'd1: ref_a = ref_a & m;
        3'd2: ref_a = ref_a ^ m;
        // SBC is ADC of the inverted operand
        3'd3, 3'd7:
        begin
          sum   = {1'b0, ref_a} + {1'b0, (opc[7] ? ~m : m)} + {8'h00, ref_c};
          ref_c = sum[8];
          ref_a = sum[7:0];
        end
        3'd4: ref_store(ea, ref_a);
        3'd6:
        begin
          ref_c = (ref_a >= m);
          ref_set_nz(ref_a - m);
        end
        default: ref_a = m;
      endcase
      if (opc[7:5] != 3'd4 && opc[7:5] != 3'd6)
        ref_set_nz(ref_a);
    end
    else
    begin
      case (opc)
        OPC_JMP: ref_pc = {hi, lo};
        8'h86, 8'h8e: ref_store(ea, ref_x);
        8'ha2, 8'ha6, 8'hae: ref_x = m;
        OPC_CLC: ref_c = 1'b0;
        OPC_SEC: ref_c = 1'b1;
        OPC_TAX: ref_x = ref_a;
        OPC_TXA: ref_a = ref_x;
        OPC_TAY: ref_y = ref_a;
        OPC_TYA: ref_a = ref_y;
        OPC_INX: ref_x = ref_x + 8'd1;
        OPC_INY: ref_y = ref_y + 8'd1;
        OPC_DEX: ref_x = ref_x - 8'd1;
        OPC_DEY: ref_y = ref_y - 8'd1;
        default: ;
      endcase
      case (opc)
        8'ha2, 8'ha6, 8'hae, OPC_TAX, OPC_INX, OPC_DEX: ref_set_nz(ref_x);
        OPC_TXA, OPC_TYA: ref_set_nz(ref_a);
        OPC_TAY, OPC_INY, OPC_DEY: ref_set_nz(ref_y);
        default: ;
      endcase
    end
  end
  return 1'b0;
endfunction

`endif

// ==== tb/tb_cpu_core.sv ====
// ==============================
// Testbench for cpu_core with bus memory and reference checks
// ==============================
`timescale 1ns/1ps

module tb_cpu_core
  import cpu_bus_pkg::*;
  import cpu_isa_pkg::*;
();

  logic    raw_clk;
  logic    button_reset;
  logic    button_halt;
  byte_t   mem_rdata;
  addr_t   mem_address;
  byte_t   mem_wdata;
  logic    mem_write;
  byte_t   acc;
  status_t status;
  addr_t   pc;
  logic    halted;
  logic    fault;

  byte_t       mem [0:65535];
  byte_t       prog_bytes [$];
  byte_t       opcode_pool [$];
  logic [31:0] lcg_state = 32'd70;

  `include "ref_model.svh"

  cpu_core dut (.*);

  initial
  begin
    raw_clk = 1'b0;
    forever #2 raw_clk = ~raw_clk;
  end

  // Synchronous read with one cycle of latency
  always @(posedge raw_clk)
  begin
    mem_rdata <= mem[mem_address];
    if (mem_write)
      mem[mem_address] <= mem_wdata;
  end

  // Each write must be the next one in the model's list
  always @(posedge raw_clk)
  begin
    if (button_reset && mem_write)
    begin
      if (ref_wr_addr.size() == 0)
        stop_run($sformatf("Unexpected memory write to %04h at %0t", mem_address, $time));
      else
      begin
        check_addr("mem_address", mem_address, ref_wr_addr.pop_front());
        check_byte("mem_wdata", mem_wdata, ref_wr_data.pop_front());
      end
    end
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t %s got %02h expected %02h", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t %s got %04h expected %04h", $time, name, got, exp));
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t %s got %08b expected %08b", $time, name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("ERROR %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Background pattern built from both address bytes
  function automatic byte_t fill_byte(input addr_t addr);
    return addr[15:8] ^ addr[7:0] ^ 8'h5a;
  endfunction

  task automatic load_memory();
    for (int i = 0; i < 65536; i++)
    begin
      mem[i]     = fill_byte(addr_t'(i));
      ref_mem[i] = mem[i];
    end
    foreach (prog_bytes[k])
    begin
      mem[16'h4000 + k]     = prog_bytes[k];
      ref_mem[16'h4000 + k] = prog_bytes[k];
    end
  endtask

  task automatic reset_core();
    @(posedge raw_clk);
    button_reset <= 1'b0;
    repeat (2)
      @(posedge raw_clk);
    button_reset <= 1'b1;
    @(negedge raw_clk);
    check_flag("mem_write", mem_write, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_flag("fault", fault, 1'b0);
    check_byte("acc", acc, 8'h00);
    check_status("status", status, 8'h20);
    check_addr("mem_address", mem_address, 16'h4000);
  endtask

  task automatic wait_for_stop(input int limit);
    int cycles;
    cycles = 0;
    while (!halted && !fault)
    begin
      @(negedge raw_clk);
      cycles++;
      if (cycles > limit)
        stop_run($sformatf("Timeout: core did not halt or fault in %0d cycles", limit));
    end
  endtask

  task automatic wait_for_resume(input int limit);
    int cycles;
    cycles = 0;
    while (halted)
    begin
      @(negedge raw_clk);
      cycles++;
      if (cycles > limit)
        stop_run("Timeout: core stayed halted after the halt button was pressed");
    end
  endtask

  task automatic check_final(input logic ref_fault);
    check_flag("fault", fault, ref_fault);
    check_flag("halted", halted, ~ref_fault);
    check_byte("acc", acc, ref_a);
    check_status("status", status, ref_status());
    check_addr("pc", pc, ref_pc);
    if (ref_wr_addr.size() != 0)
      stop_run($sformatf("%0d expected memory writes never happened", ref_wr_addr.size()));
  endtask

  task automatic run_program(input int limit);
    logic ref_fault;
    load_memory();
    ref_reset();
    ref_fault = run_reference(1000);
    reset_core();
    wait_for_stop(limit);
    check_final(ref_fault);
  endtask

  task automatic build_opcode_pool();
    byte_t opc;
    for (int i = 0; i < 256; i++)
    begin
      opc = byte_t'(i);
      if (ref_mode(opc) >= 0 && opc != OPC_BRK && opc != OPC_JMP)
        opcode_pool.push_back(opc);
    end
  endtask

  // Absolute operands stay in page 2 so the program is never overwritten
  task automatic build_random_program();
    byte_t opc;
    int    mode;
    int    count;
    prog_bytes.delete();
    count = 8 + (lcg_next() >> 16) % 16;
    for (int i = 0; i < count; i++)
    begin
      opc  = opcode_pool[(lcg_next() >> 16) % opcode_pool.size()];
      mode = ref_mode(opc);
      prog_bytes.push_back(opc);
      if (mode != 0)
        prog_bytes.push_back(byte_t'(lcg_next() >> 16));
      if (mode >= 4)
        prog_bytes.push_back(8'h02);
    end
    prog_bytes.push_back(OPC_BRK);
  endtask

  initial
  begin : stimulus
    logic resume_fault;
    button_reset = 1'b0;
    button_halt  = 1'b1;
    mem_rdata    = 8'h00;

    // Immediate ALU ops and carry control
    prog_bytes = '{8'ha9, 8'h35, 8'h69, 8'h4a, 8'h38, 8'he9, 8'h10, 8'h29, 8'hf0,
                   8'h09, 8'h0c, 8'h49, 8'hff, 8'hc9, 8'h30, 8'h18, 8'h69, 8'h80,
                   8'hc9, 8'hf0, 8'h00};
    run_program(500);

    // All modes, stores and register moves including the zp,x wrap
    prog_bytes = '{8'ha2, 8'h05, 8'ha9, 8'h77, 8'h85, 8'h10, 8'h95, 8'h10,
                   8'h8d, 8'h00, 8'h02, 8'h9d, 8'h00, 8'h02, 8'ha8, 8'hc8,
                   8'h99, 8'h00, 8'h03, 8'h86, 8'h20, 8'h8e, 8'h10, 8'h02,
                   8'ha6, 8'h15, 8'he8, 8'h8a, 8'hca, 8'h88, 8'h98, 8'haa,
                   8'ha2, 8'hf0, 8'hb5, 8'h20, 8'h95, 8'h30, 8'had, 8'h00, 8'h02,
                   8'hbd, 8'hf0, 8'h01, 8'hb9, 8'h00, 8'h03, 8'h6d, 8'h10, 8'h02,
                   8'h00};
    run_program(1000);

    build_opcode_pool();
    repeat (20)
    begin
      build_random_program();
      run_program(1000);
    end

    // JMP over illegal filler, BRK, then resume on a halt press
    prog_bytes = '{8'h4c, 8'h08, 8'h40, 8'ha9, 8'hff, 8'h02, 8'h02, 8'h02,
                   8'ha9, 8'h11, 8'h00, 8'ha2, 8'h22, 8'h8a, 8'h69, 8'h01, 8'h00};
    run_program(200);
    repeat (20)
    begin
      @(negedge raw_clk);
      check_flag("halted", halted, 1'b1);
      check_addr("pc", pc, ref_pc);
    end
    resume_fault = run_reference(100);
    @(posedge raw_clk);
    button_halt <= 1'b0;
    @(posedge raw_clk);
    button_halt <= 1'b1;
    wait_for_resume(20);
    wait_for_stop(200);
    check_final(resume_fault);

    // Illegal cc=11 opcode after one store
    prog_bytes = '{8'ha9, 8'h42, 8'h8d, 8'h00, 8'h02, 8'h03, 8'h8d, 8'h01, 8'h02, 8'h00};
    run_program(200);
    repeat (40)
    begin
      @(negedge raw_clk);
      check_flag("halted", halted, 1'b0);
      check_flag("fault", fault, 1'b1);
      check_flag("mem_write", mem_write, 1'b0);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/cpu_bus_pkg.sv
logic/cpu_isa_pkg.sv
logic/exec_if.sv
logic/opcode_decoder.sv
logic/bus_sequencer.sv
logic/alu_datapath.sv
logic/cpu_core.sv
tb/tb_cpu_core.sv
